/* logic/pi_pkg.sv */
// widths, operation codes, typedefs and the request struct shared
// by the master queue, its slot memory and the slave word memory
`default_nettype none

package pi_pkg;

	// four masters, and each of them owns exactly one queue slot
	localparam int unsigned MASTER_COUNT = 4;
	localparam int unsigned SLOT_W = 2;
	// the extra top bit tells a full queue apart from an empty one
	localparam int unsigned PTR_W = SLOT_W + 1;
	localparam int unsigned DATA_W = 16;
	// one select per byte lane of a word
	localparam int unsigned SEL_W = DATA_W / 8;
	localparam int unsigned ADDR_W = 8;
	localparam int unsigned MEM_WORDS = 1 << ADDR_W;

	typedef logic [1:0] pi_op_t;
	typedef logic [SLOT_W-1:0] pi_slot_t;
	typedef logic [PTR_W-1:0] pi_ptr_t;
	typedef logic [ADDR_W-1:0] pi_addr_t;
	typedef logic [DATA_W-1:0] pi_data_t;
	typedef logic [SEL_W-1:0] pi_sel_t;

	// bit 1 set means the slave hands a word back
	// bit 0 set means the slave stores the data bytes
	localparam pi_op_t PI_NOOP = 2'd0;
	localparam pi_op_t PI_WROP = 2'd1;
	localparam pi_op_t PI_RDOP = 2'd2;
	localparam pi_op_t PI_RWOP = 2'd3;

	// one memory operation as issued by a master and queued for the slave
	typedef struct packed {
		pi_op_t   op;
		pi_addr_t addr;
		pi_data_t data;
		pi_sel_t  sel;
	} pi_req_t;

endpackage

`default_nettype wire

/* logic/pi_queue_ram.sv */
// slot memory of the master queue, one request per master
// with a clocked write port and combinational read ports
`default_nettype none
`timescale 1ns/1ps

module pi_queue_ram import pi_pkg::*; (
	input  logic     m_clk_i,
	input  logic     we_i,
	input  pi_slot_t waddr_i,
	input  pi_req_t  wreq_i,
	input  pi_slot_t raddr_i,
	output pi_req_t  rreq_o,
	output pi_op_t   wop_o
);

	// slot i is only ever written with a request from master i
	pi_req_t mem_q [MASTER_COUNT];

	always_ff @(posedge m_clk_i) begin
		if (we_i) begin
			mem_q[waddr_i] <= wreq_i;
		end
	end

	// the read side feeds the slave directly without a register stage
	assign rreq_o = mem_q[raddr_i];

	// old op still sitting in the slot about to be overwritten
	// the queue uses it to hold back a master whose read may be in flight
	assign wop_o = mem_q[waddr_i].op;

endmodule

`default_nettype wire

/* logic/pi_slave_ram.sv */
// slave word memory with byte selects, read-write swap
// and a single wait state on every data-returning operation
`default_nettype none
`timescale 1ns/1ps

module pi_slave_ram import pi_pkg::*; (
	input  logic     m_clk_i,
	input  logic     rst_i,
	input  pi_req_t  s_req_i,
	output logic     s_rdy_o,
	output pi_data_t s_data_o
);

	pi_data_t mem_q [MEM_WORDS];
	// word handed back to the queue, held until the next read
	pi_data_t rdata_q;
	// high for the one stall cycle after a read or read-write
	logic wait_q;
	logic take;

	assign s_rdy_o = !wait_q;

	// the request is only looked at while ready is high
	assign take = s_rdy_o && (s_req_i.op != PI_NOOP);

	assign s_data_o = rdata_q;

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			wait_q <= 1'b0;
		end else if (wait_q) begin
			wait_q <= 1'b0;
		end else if (take && s_req_i.op[1]) begin
			wait_q <= 1'b1;
		end
	end

	// a read-write samples the old word on the same edge that
	// stores the new bytes, so the swap needs no extra cycle
	always_ff @(posedge m_clk_i) begin
		if (take) begin
			if (s_req_i.op[1]) begin
				rdata_q <= mem_q[s_req_i.addr];
			end
			if (s_req_i.op[0]) begin
				for (int b = 0; b < SEL_W; b++) begin
					// lanes without a select keep their old byte
					if (s_req_i.sel[b]) begin
						mem_q[s_req_i.addr][b*(DATA_W/SEL_W) +: DATA_W/SEL_W] <=
							s_req_i.data[b*(DATA_W/SEL_W) +: DATA_W/SEL_W];
					end
				end
			end
		end
	end

	// the stall is exactly one cycle and never stretches
	a_one_wait: assert property (@(posedge m_clk_i) disable iff (rst_i)
		wait_q |=> !wait_q)
		else $error("slave wait state lasted more than one cycle");

endmodule

`default_nettype wire

/* logic/pi_master_queue.sv */
// fixed-slot queue between four masters and one slave, with the rotation
// limit scanner, ready generation and per-master read-result registers
`default_nettype none
`timescale 1ns/1ps

module pi_master_queue import pi_pkg::*; (
	input  logic                    m_clk_i,
	input  logic                    rst_i,
	input  pi_req_t                 m_req_i [MASTER_COUNT],
	output logic [MASTER_COUNT-1:0] m_rdy_o,
	output pi_data_t                m_data_o [MASTER_COUNT],
	output pi_req_t                 s_req_o,
	input  pi_data_t                s_data_i,
	input  logic                    s_rdy_i
);

	// write and read pointers, the low bits pick the slot
	pi_ptr_t wptr_q;
	pi_ptr_t rptr_q;
	pi_ptr_t wptr_nxt;
	pi_ptr_t rptr_nxt;
	pi_slot_t wslot;
	pi_slot_t rslot;
	// rotation limits seen by the write side and by the read side
	pi_slot_t wr_hi_q;
	pi_slot_t rd_hi_q;
	// distance from the last slot of a rotation to slot 0 of the next lap
	pi_ptr_t wr_step;
	pi_ptr_t rd_step_q;
	// scanner state looking for the highest active master
	pi_slot_t scan_q;
	pi_slot_t hi_nxt_q;
	logic scan_hit;
	// slot whose read result comes back on the next slave ready
	pi_slot_t prev_slot_q;
	logic run_q;
	pi_ptr_t q_fill;
	pi_ptr_t q_fill_nxt;
	logic q_empty;
	logic q_full;
	logic q_near;
	logic rdy_ok;
	logic m_we;
	logic s_take;
	pi_req_t q_rreq;
	pi_op_t q_wop;

	assign wslot = wptr_q[SLOT_W-1:0];
	assign rslot = rptr_q[SLOT_W-1:0];

	// a lap that stops at wr_hi_q jumps over the unused slots in one step
	assign wr_step = pi_ptr_t'(MASTER_COUNT) - pi_ptr_t'(wr_hi_q);
	assign wptr_nxt = (wslot < wr_hi_q) ? wptr_q + 1'b1 : wptr_q + wr_step;
	assign rptr_nxt = (rslot < rd_hi_q) ? rptr_q + 1'b1 : rptr_q + rd_step_q;

	assign q_fill = wptr_q - rptr_q;
	assign q_fill_nxt = wptr_nxt - rptr_q;
	assign q_empty = (wptr_q == rptr_q);
	assign q_full = (q_fill == pi_ptr_t'(MASTER_COUNT));
	// near full means the slot to be written is the one the slave took last,
	// so its read data may not have landed in the master's register yet
	assign q_near = (q_fill_nxt == pi_ptr_t'(MASTER_COUNT)) || q_full;

	// both sides must agree on the rotation before a new lap is filled
	assign rdy_ok = run_q && (wr_hi_q == rd_hi_q) && !q_full && !(q_near && q_wop[1]);

	always_comb begin
		for (int i = 0; i < MASTER_COUNT; i++) begin
			m_rdy_o[i] = rdy_ok && (wslot == pi_slot_t'(i));
		end
	end

	// only the master owning the write slot can be ready
	assign m_we = |m_rdy_o;
	assign s_take = s_rdy_i && !q_empty;

	pi_queue_ram slots_i (
		.m_clk_i (m_clk_i),
		.we_i    (m_we),
		.waddr_i (wslot),
		.wreq_i  (m_req_i[wslot]),
		.raddr_i (rslot),
		.rreq_o  (q_rreq),
		.wop_o   (q_wop)
	);

	// an empty queue shows the slave a no-op and leaves the rest as is
	always_comb begin
		s_req_o = q_rreq;
		if (q_empty) begin
			s_req_o.op = PI_NOOP;
		end
	end

	// walk down from the top master and stop at the first one with work
	// a hit below slot 1 still keeps the limit at 1
	assign scan_hit = (m_req_i[scan_q].op != PI_NOOP);

	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			scan_q <= pi_slot_t'(MASTER_COUNT - 1);
			hi_nxt_q <= pi_slot_t'(MASTER_COUNT - 1);
		end else if (scan_hit || (scan_q == '0)) begin
			if (scan_hit) begin
				hi_nxt_q <= (scan_q != '0) ? scan_q : pi_slot_t'(1);
			end
			scan_q <= pi_slot_t'(MASTER_COUNT - 1);
		end else begin
			scan_q <= scan_q - 1'b1;
		end
	end

	// write side takes the scanned limit each time its lap wraps
	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			wptr_q <= '0;
			wr_hi_q <= pi_slot_t'(MASTER_COUNT - 1);
			// matches a full lap over all masters
			rd_step_q <= pi_ptr_t'(1);
			run_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (m_we) begin
				wptr_q <= wptr_nxt;
				if (!(wslot < wr_hi_q)) begin
					// the read side still needs the step of the lap just closed
					rd_step_q <= wr_step;
					wr_hi_q <= hi_nxt_q;
				end
			end
		end
	end

	// read side follows the write side limit once its own lap wraps
	always_ff @(posedge m_clk_i) begin
		if (rst_i) begin
			rptr_q <= '0;
			rd_hi_q <= pi_slot_t'(MASTER_COUNT - 1);
			prev_slot_q <= '0;
		end else if (s_take) begin
			rptr_q <= rptr_nxt;
			prev_slot_q <= rslot;
			if (!(rslot < rd_hi_q)) begin
				rd_hi_q <= wr_hi_q;
			end
		end
	end

	// the slave raises its ready together with the word of the previous op
	always_ff @(posedge m_clk_i) begin
		if (s_rdy_i) begin
			m_data_o[prev_slot_q] <= s_data_i;
		end
	end

	a_one_ready: assert property (@(posedge m_clk_i) disable iff (rst_i)
		$onehot0(m_rdy_o))
		else $error("more than one master ready in the same cycle");

	a_ptr_span: assert property (@(posedge m_clk_i) disable iff (rst_i)
		q_fill <= pi_ptr_t'(MASTER_COUNT))
		else $error("write pointer ran more than one lap ahead of read pointer");

endmodule

`default_nettype wire

/* logic/pi_subsystem_top.sv */
// shared-memory port top level
// the master queue feeding the slave word memory
`default_nettype none
`timescale 1ns/1ps

module pi_subsystem_top import pi_pkg::*; (
	input  logic                    m_clk_i,
	input  logic                    rst_i,
	input  pi_req_t                 m_req_i [MASTER_COUNT],
	output logic [MASTER_COUNT-1:0] m_rdy_o,
	output pi_data_t                m_data_o [MASTER_COUNT]
);

	// request toward the slave, a no-op while the queue is empty
	pi_req_t s_req;
	// slave ready, low for the wait state of a read
	logic s_rdy;
	// word returned by the slave
	pi_data_t s_data;

	pi_master_queue queue_i (
		.m_clk_i  (m_clk_i),
		.rst_i    (rst_i),
		.m_req_i  (m_req_i),
		.m_rdy_o  (m_rdy_o),
		.m_data_o (m_data_o),
		.s_req_o  (s_req),
		.s_data_i (s_data),
		.s_rdy_i  (s_rdy)
	);

	// both blocks share the master clock
	pi_slave_ram slave_i (
		.m_clk_i  (m_clk_i),
		.rst_i    (rst_i),
		.s_req_i  (s_req),
		.s_rdy_o  (s_rdy),
		.s_data_o (s_data)
	);

endmodule

`default_nettype wire

/* verif/pi_tb_clk.sv */
// testbench clock of 4 ns and a reset held for 8 cycles
`default_nettype none
`timescale 1ns/1ps

module pi_tb_clk (
	output logic m_clk_o,
	output logic rst_o
);

	initial begin
		m_clk_o = 1'b0;
		forever #2 m_clk_o = ~m_clk_o;
	end

	// reset drops on a falling edge like every other DUT input
	initial begin
		rst_o = 1'b1;
		repeat (8) @(posedge m_clk_o);
		@(negedge m_clk_o);
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

/* verif/pi_subsystem_tb.sv */
// testbench for the shared-memory port with directed and random master traffic,
// a reference model of the slave memory and checks of readies and returned words
`default_nettype none
`timescale 1ns/1ps

module pi_subsystem_tb import pi_pkg::*; ();

	localparam logic [31:0] SEED = 32'h8d14_2b78;
	localparam int MODE_DIRECT = 0;
	localparam int MODE_RANDOM = 1;
	localparam int MODE_PAIR = 2;
	localparam int DIRECT_ACC = 24;
	localparam int RANDOM_ACC = 400;
	localparam int PAIR_ACC = 60;
	// up to ten accepts still belong to laps of the full rotation
	// before the shrunken one takes over
	localparam int PAIR_SETTLE = 10;
	localparam int RESET_WAIT = 40;
	// random traffic stays inside eight words so masters collide
	localparam pi_addr_t WIN_BASE = 8'h10;

	logic m_clk;
	logic rst;
	pi_req_t m_req [MASTER_COUNT];
	logic [MASTER_COUNT-1:0] m_rdy;
	pi_data_t m_data [MASTER_COUNT];

	// reference memory and a per-bit mask of words that were ever written
	pi_data_t ref_mem [MEM_WORDS];
	pi_data_t ref_known [MEM_WORDS];
	// expected word for each master on its next ready
	pi_data_t pend_val [MASTER_COUNT];
	pi_data_t pend_mask [MASTER_COUNT];
	logic pend_on [MASTER_COUNT];
	logic just_acc [MASTER_COUNT];
	int step [MASTER_COUNT];
	int since [MASTER_COUNT][MASTER_COUNT];
	logic seen [MASTER_COUNT];
	int mode;
	int last_m;
	int pair_acc;
	int acc_total;
	int errors;
	logic [31:0] rng;

	pi_tb_clk clk_gen_i (
		.m_clk_o (m_clk),
		.rst_o   (rst)
	);

	pi_subsystem_top dut_i (
		.m_clk_i  (m_clk),
		.rst_i    (rst),
		.m_req_i  (m_req),
		.m_rdy_o  (m_rdy),
		.m_data_o (m_data)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// bit mask of the byte lanes a select vector touches
	function automatic pi_data_t lane_mask(input pi_sel_t sel);
		pi_data_t m;
		m = '0;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				m[b*8 +: 8] = 8'hff;
			end
		end
		return m;
	endfunction

	// word the slave holds after a write or read-write with these selects
	function automatic pi_data_t merge_word(input pi_data_t old_w, input pi_data_t new_w,
		input pi_sel_t sel);
		pi_data_t m;
		m = lane_mask(sel);
		return (old_w & ~m) | (new_w & m);
	endfunction

	// write, read back, partial write, read, read-write swap, read again
	function automatic pi_req_t directed_req(input int m, input int s);
		pi_req_t r;
		r.addr = pi_addr_t'(32'h40 + m);
		r.sel = 2'b11;
		r.data = '0;
		r.op = PI_RDOP;
		case (s)
			0: begin
				r.op = PI_WROP;
				r.data = pi_data_t'(32'ha05c + m);
			end
			2: begin
				r.op = PI_WROP;
				r.data = pi_data_t'(32'h3391 + m);
				r.sel = 2'b01;
			end
			4: begin
				r.op = PI_RWOP;
				r.data = pi_data_t'(32'h7e0f + m);
				r.sel = 2'b10;
			end
			default: r.op = PI_RDOP;
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		if (exp !== got) begin
			errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic make_random(input int m, output pi_req_t r);
		rng = xorshift32(rng);
		r.op = rng[1:0];
		r.addr = WIN_BASE + pi_addr_t'(rng[4:2]);
		r.sel = rng[6:5];
		rng = xorshift32(rng);
		r.data = rng[15:0];
		// the top master keeps the full rotation alive unless the pair mode runs
		if (mode == MODE_PAIR) begin
			if (m >= 2) begin
				r.op = PI_NOOP;
			end else if (m == 1 && r.op == PI_NOOP) begin
				r.op = PI_RDOP;
			end
		end else if (m == MASTER_COUNT - 1 && r.op == PI_NOOP) begin
			r.op = PI_RDOP;
		end
	endtask

	// the request driven now is taken on the coming rising edge
	task automatic apply_accept(input int m);
		pi_req_t r;
		r = m_req[m];
		if (r.op[1]) begin
			pend_val[m] <= ref_mem[r.addr];
			pend_mask[m] <= ref_known[r.addr];
			pend_on[m] <= 1'b1;
		end else begin
			pend_on[m] <= 1'b0;
		end
		if (r.op[0]) begin
			ref_mem[r.addr] = merge_word(ref_mem[r.addr], r.data, r.sel);
			ref_known[r.addr] = ref_known[r.addr] | lane_mask(r.sel);
		end
		if (mode != MODE_PAIR) begin
			// every other master gets exactly one turn between two turns of m
			if (seen[m]) begin
				for (int j = 0; j < MASTER_COUNT; j++) begin
					if (j != m) begin
						check_value($sformatf("accepts of master %0d between master %0d", j, m),
							1, since[m][j]);
					end
				end
			end
			seen[m] = 1'b1;
			for (int k = 0; k < MASTER_COUNT; k++) begin
				since[m][k] = 0;
				if (k != m) begin
					since[k][m]++;
				end
			end
		end else begin
			pair_acc++;
			if (pair_acc > PAIR_SETTLE) begin
				check_value("accepted master", (last_m == 0) ? 1 : 0, m);
			end
		end
		last_m = m;
	endtask

	// one falling edge: refresh taken requests, then model the coming accepts
	task automatic cycle_step(output int taken);
		pi_req_t r;
		taken = 0;
		@(negedge m_clk);
		for (int m = 0; m < MASTER_COUNT; m++) begin
			if (just_acc[m]) begin
				if (step[m] < 6) begin
					m_req[m] = directed_req(m, step[m]);
					step[m]++;
				end else begin
					make_random(m, r);
					m_req[m] = r;
				end
				just_acc[m] = 1'b0;
			end
		end
		for (int m = 0; m < MASTER_COUNT; m++) begin
			if (m_rdy[m]) begin
				apply_accept(m);
				just_acc[m] = 1'b1;
				taken++;
			end
		end
		if (mode == MODE_PAIR && pair_acc > PAIR_SETTLE) begin
			check_value("m_rdy_o[3:2]", 0, m_rdy[3:2]);
		end
	endtask

	task automatic run_phase(input int new_mode, input int n);
		int got;
		int taken;
		int guard;
		got = 0;
		guard = 0;
		mode = new_mode;
		if (mode == MODE_PAIR) begin
			// masters 2 and 3 go idle even if their last request was never taken
			// a request already modeled for the coming edge stays until its refresh
			for (int m = 2; m < MASTER_COUNT; m++) begin
				if (!just_acc[m]) begin
					m_req[m].op = PI_NOOP;
				end
			end
			pair_acc = 0;
		end
		while (got < n && guard < n * 20 + 200) begin
			cycle_step(taken);
			got += taken;
			guard++;
		end
		acc_total += got;
		if (got < n) begin
			errors++;
			$display("timeout in phase %0d, only %0d of %0d requests were accepted",
				new_mode, got, n);
		end
	endtask

	// readies never overlap, and a ready delivers the pending read result
	always @(negedge m_clk) begin
		if (!rst) begin
			check_value("number of m_rdy_o bits high", 1, $countones(m_rdy) <= 1);
			for (int m = 0; m < MASTER_COUNT; m++) begin
				if (m_rdy[m] && pend_on[m]) begin
					check_value($sformatf("m_data_o[%0d]", m), pend_val[m] & pend_mask[m],
						m_data[m] & pend_mask[m]);
				end
			end
		end
	end

	initial begin
		int guard;
		errors = 0;
		acc_total = 0;
		rng = SEED;
		mode = MODE_DIRECT;
		last_m = 0;
		pair_acc = 0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			ref_mem[a] = '0;
			ref_known[a] = '0;
		end
		for (int m = 0; m < MASTER_COUNT; m++) begin
			m_req[m] = directed_req(m, 0);
			step[m] = 1;
			pend_val[m] = '0;
			pend_mask[m] = '0;
			pend_on[m] = 1'b0;
			just_acc[m] = 1'b0;
			seen[m] = 1'b0;
			for (int k = 0; k < MASTER_COUNT; k++) begin
				since[m][k] = 0;
			end
		end
		// no master may be ready while reset is held
		// reset drops on a falling edge, so it is looked at on rising ones
		guard = 0;
		@(posedge m_clk);
		while (rst && guard < RESET_WAIT) begin
			@(negedge m_clk);
			check_value("m_rdy_o during reset", 0, m_rdy);
			@(posedge m_clk);
			guard++;
		end
		if (rst) begin
			errors++;
			$display("reset was never released");
		end else begin
			run_phase(MODE_DIRECT, DIRECT_ACC);
			run_phase(MODE_RANDOM, RANDOM_ACC);
			run_phase(MODE_PAIR, PAIR_ACC);
		end
		$display("accepted requests %0d, errors %0d", acc_total, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
logic/pi_pkg.sv
logic/pi_queue_ram.sv
logic/pi_slave_ram.sv
logic/pi_master_queue.sv
logic/pi_subsystem_top.sv
verif/pi_tb_clk.sv
verif/pi_subsystem_tb.sv

/* Makefile */
# Verilator build for the shared-memory port testbench
# every variable below can be overridden on the command line

TOP       ?= pi_subsystem_tb
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the testbench printed the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "TEST OK"; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
